// File: verilog/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] inst_t;

    ////////////////////////////////////////
    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // function codes under OP_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_JALR = 6'h09;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // rt field under OP_REGIMM
    localparam logic [4:0] RT_BLTZ   = 5'h00;
    localparam logic [4:0] RT_BGEZ   = 5'h01;
    localparam logic [4:0] RT_BLTZAL = 5'h10;
    localparam logic [4:0] RT_BGEZAL = 5'h11;

    localparam reg_addr_t REG_LINK    = 5'd31;
    localparam word_t     LINK_OFFSET = 32'd8;

    // one-hot, add sits in the msb
    typedef struct packed {
        logic add;
        logic sub;
        logic slt;
        logic sltu;
        logic and_op;
        logic nor_op;
        logic or_op;
        logic xor_op;
        logic sll;
        logic srl;
        logic sra;
        logic lui;
    } alu_op_t;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BGEZ,
        BR_BGTZ,
        BR_BLEZ,
        BR_BLTZ,
        BR_J,
        BR_JR
    } br_kind_t;

endpackage

`default_nettype wire

// File: verilog/id_bus_pkg.sv
`default_nettype none

package id_bus_pkg;

    import mips_isa_pkg::*;

    typedef struct packed {
        logic if_stop;
        logic id_stop;
    } stall_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
    } if_id_t;

    // writeback port of the register file
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } reg_write_t;

    // result forwarded from execute or memory
    typedef struct packed {
        logic      is_load;
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } fwd_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic [2:0] src1_sel;
        logic [3:0] src2_sel;
        logic      ram_en;
        logic [3:0] ram_wen;
        logic      rf_we;
        reg_addr_t rf_waddr;
        logic      rf_from_mem;
        br_kind_t  br_kind;
        logic      link;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        inst_t inst;
        ctrl_t ctrl;
        word_t rs_val;
        word_t rt_val;
    } id_ex_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } branch_t;

endpackage

`default_nettype wire

// File: verilog/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile
    import mips_isa_pkg::*, id_bus_pkg::*;
(
    input  logic       clk,
    input  reg_addr_t  raddr1,
    input  reg_addr_t  raddr2,
    output word_t      rdata1,
    output word_t      rdata2,
    input  reg_write_t wr
);

    word_t regs [32];

    // $zero is never stored
    always_ff @(posedge clk) begin
        if (wr.we && wr.waddr != '0) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    // entry 0 has no storage behind it, force zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: verilog/if_id_hold.sv
`timescale 1ns/1ns
`default_nettype none

module if_id_hold
    import mips_isa_pkg::*, id_bus_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  stall_t stall,
    input  if_id_t if_id,
    input  inst_t  inst_rdata,
    output logic   valid,
    output word_t  pc,
    output inst_t  inst
);

    if_id_t pc_q;
    logic   hold_vld;
    inst_t  hold_inst;

    ////////////////////////////////////////
    // pc register
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= '0;
        end else if (stall.if_stop && !stall.id_stop) begin
            // fetch held but decode moves on, so push a bubble
            pc_q <= '0;
        end else if (!stall.if_stop) begin
            pc_q <= if_id;
        end
    end

    assign valid = pc_q.valid;
    assign pc    = pc_q.pc;

    ////////////////////////////////////////
    // instruction hold buffer
    // sram data moves on while decode stalls, keep the first stalled word
    always_ff @(posedge clk) begin
        if (rst) begin
            hold_vld  <= 1'b0;
            hold_inst <= '0;
        end else if (stall.id_stop && !hold_vld) begin
            hold_vld  <= 1'b1;
            hold_inst <= inst_rdata;
        end else if (!stall.id_stop) begin
            hold_vld  <= 1'b0;
        end
    end

    assign inst = hold_vld ? hold_inst : inst_rdata;

endmodule

`default_nettype wire

// File: verilog/operand_bypass.sv
`timescale 1ns/1ns
`default_nettype none

module operand_bypass
    import mips_isa_pkg::*, id_bus_pkg::*;
(
    input  logic       valid,
    input  reg_addr_t  rs,
    input  reg_addr_t  rt,
    input  word_t      rf_rs,
    input  word_t      rf_rt,
    input  fwd_t       ex_fwd,
    input  fwd_t       mem_fwd,
    input  reg_write_t wb,
    output word_t      rs_val,
    output word_t      rt_val,
    output logic       stallreq
);

    logic ex_hit_rs;
    logic ex_hit_rt;

    // newest producer wins, writes to $zero never match
    function automatic word_t pick(
        input reg_addr_t  addr,
        input word_t      rf_val,
        input fwd_t       ex,
        input fwd_t       mem,
        input reg_write_t wbk
    );
        word_t val;
        val = rf_val;
        if (addr != '0) begin
            if (ex.we && ex.waddr == addr) begin
                val = ex.wdata;
            end else if (mem.we && mem.waddr == addr) begin
                val = mem.wdata;
            end else if (wbk.we && wbk.waddr == addr) begin
                val = wbk.wdata;
            end
        end
        return val;
    endfunction

    assign rs_val = pick(rs, rf_rs, ex_fwd, mem_fwd, wb);
    assign rt_val = pick(rt, rf_rt, ex_fwd, mem_fwd, wb);

    ////////////////////////////////////////
    // load-use hazard
    // load data is not ready until memory, so decode must wait a cycle
    assign ex_hit_rs = ex_fwd.waddr == rs;
    assign ex_hit_rt = ex_fwd.waddr == rt;

    assign stallreq = valid && ex_fwd.is_load && ex_fwd.we && ex_fwd.waddr != '0
                      && (ex_hit_rs || ex_hit_rt);

endmodule

`default_nettype wire

// File: verilog/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module inst_decoder
    import mips_isa_pkg::*, id_bus_pkg::*;
(
    input  logic  valid,
    input  inst_t inst,
    output ctrl_t ctrl
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic       is_r;
    logic       is_ri;

    logic i_sll, i_srl, i_sra, i_sllv, i_srlv, i_srav;
    logic i_jr, i_jalr;
    logic i_add, i_addu, i_sub, i_subu, i_and, i_or, i_xor, i_nor, i_slt, i_sltu;
    logic i_bltz, i_bgez, i_bltzal, i_bgezal;
    logic i_j, i_jal, i_beq, i_bne, i_blez, i_bgtz;
    logic i_addi, i_addiu, i_slti, i_sltiu, i_andi, i_ori, i_xori, i_lui;
    logic i_lw, i_sw;

    logic r_alu;
    logic i_alu;
    logic zimm;
    logic links;

    assign opcode = inst[31:26];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign funct  = inst[5:0];

    // valid folded into every match, so bubbles decode to nothing
    assign is_r  = valid && opcode == OP_SPECIAL;
    assign is_ri = valid && opcode == OP_REGIMM;

    ////////////////////////////////////////
    // instruction match
    assign i_sll  = is_r && funct == FN_SLL;
    assign i_srl  = is_r && funct == FN_SRL;
    assign i_sra  = is_r && funct == FN_SRA;
    assign i_sllv = is_r && funct == FN_SLLV;
    assign i_srlv = is_r && funct == FN_SRLV;
    assign i_srav = is_r && funct == FN_SRAV;
    assign i_jr   = is_r && funct == FN_JR;
    assign i_jalr = is_r && funct == FN_JALR;
    assign i_add  = is_r && funct == FN_ADD;
    assign i_addu = is_r && funct == FN_ADDU;
    assign i_sub  = is_r && funct == FN_SUB;
    assign i_subu = is_r && funct == FN_SUBU;
    assign i_and  = is_r && funct == FN_AND;
    assign i_or   = is_r && funct == FN_OR;
    assign i_xor  = is_r && funct == FN_XOR;
    assign i_nor  = is_r && funct == FN_NOR;
    assign i_slt  = is_r && funct == FN_SLT;
    assign i_sltu = is_r && funct == FN_SLTU;

    assign i_bltz   = is_ri && rt == RT_BLTZ;
    assign i_bgez   = is_ri && rt == RT_BGEZ;
    assign i_bltzal = is_ri && rt == RT_BLTZAL;
    assign i_bgezal = is_ri && rt == RT_BGEZAL;

    assign i_j     = valid && opcode == OP_J;
    assign i_jal   = valid && opcode == OP_JAL;
    assign i_beq   = valid && opcode == OP_BEQ;
    assign i_bne   = valid && opcode == OP_BNE;
    assign i_blez  = valid && opcode == OP_BLEZ;
    assign i_bgtz  = valid && opcode == OP_BGTZ;
    assign i_addi  = valid && opcode == OP_ADDI;
    assign i_addiu = valid && opcode == OP_ADDIU;
    assign i_slti  = valid && opcode == OP_SLTI;
    assign i_sltiu = valid && opcode == OP_SLTIU;
    assign i_andi  = valid && opcode == OP_ANDI;
    assign i_ori   = valid && opcode == OP_ORI;
    assign i_xori  = valid && opcode == OP_XORI;
    assign i_lui   = valid && opcode == OP_LUI;
    assign i_lw    = valid && opcode == OP_LW;
    assign i_sw    = valid && opcode == OP_SW;

    // groups that share selects
    assign r_alu = i_add | i_addu | i_sub | i_subu | i_and | i_or | i_xor | i_nor
                 | i_slt | i_sltu | i_sll | i_srl | i_sra | i_sllv | i_srlv | i_srav;
    assign zimm  = i_andi | i_ori | i_xori;
    assign i_alu = i_addi | i_addiu | i_slti | i_sltiu | zimm | i_lui;
    assign links = i_jal | i_jalr | i_bltzal | i_bgezal;

    ////////////////////////////////////////
    // control word
    always_comb begin
        ctrl = '0;

        ctrl.alu_op.add    = i_add | i_addu | i_addi | i_addiu | i_lw | i_sw | links;
        ctrl.alu_op.sub    = i_sub | i_subu;
        ctrl.alu_op.slt    = i_slt | i_slti;
        ctrl.alu_op.sltu   = i_sltu | i_sltiu;
        ctrl.alu_op.and_op = i_and | i_andi;
        ctrl.alu_op.nor_op = i_nor;
        ctrl.alu_op.or_op  = i_or | i_ori;
        ctrl.alu_op.xor_op = i_xor | i_xori;
        ctrl.alu_op.sll    = i_sll | i_sllv;
        ctrl.alu_op.srl    = i_srl | i_srlv;
        ctrl.alu_op.sra    = i_sra | i_srav;
        ctrl.alu_op.lui    = i_lui;

        // src1: {sa, pc, rs}
        ctrl.src1_sel = {i_sll | i_srl | i_sra, links,
                         (r_alu & ~(i_sll | i_srl | i_sra)) | (i_alu & ~i_lui)
                         | i_lw | i_sw | i_jr};
        // src2: {zimm, link offset, simm, rt}
        ctrl.src2_sel = {zimm, links, i_addi | i_addiu | i_slti | i_sltiu | i_lui
                         | i_lw | i_sw, r_alu};

        ctrl.ram_en      = i_lw | i_sw;
        ctrl.ram_wen     = {4{i_sw}};
        ctrl.rf_we       = r_alu | i_alu | i_lw | links;
        ctrl.rf_from_mem = i_lw;
        ctrl.link        = links;

        if (r_alu || i_jalr) begin
            ctrl.rf_waddr = rd;
        end else if (i_alu || i_lw) begin
            ctrl.rf_waddr = rt;
        end else if (i_jal || i_bltzal || i_bgezal) begin
            ctrl.rf_waddr = REG_LINK;
        end

        if (i_beq) ctrl.br_kind = BR_BEQ;
        else if (i_bne) ctrl.br_kind = BR_BNE;
        else if (i_bgez || i_bgezal) ctrl.br_kind = BR_BGEZ;
        else if (i_bgtz) ctrl.br_kind = BR_BGTZ;
        else if (i_blez) ctrl.br_kind = BR_BLEZ;
        else if (i_bltz || i_bltzal) ctrl.br_kind = BR_BLTZ;
        else if (i_j || i_jal) ctrl.br_kind = BR_J;
        else if (i_jr || i_jalr) ctrl.br_kind = BR_JR;
    end

endmodule

`default_nettype wire

// File: verilog/branch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module branch_unit
    import mips_isa_pkg::*, id_bus_pkg::*;
(
    input  word_t   pc,
    input  inst_t   inst,
    input  ctrl_t   ctrl,
    input  word_t   rs_val,
    input  word_t   rt_val,
    output branch_t br
);

    word_t pc_plus_4;
    word_t br_target;
    word_t j_target;
    logic  rs_neg;
    logic  rs_zero;
    logic  rs_eq_rt;

    assign pc_plus_4 = pc + 32'd4;

    // word offset relative to the delay slot
    assign br_target = pc_plus_4 + {{14{inst[15]}}, inst[15:0], 2'b00};
    // stays inside the current 256 MB region
    assign j_target  = {pc_plus_4[31:28], inst[25:0], 2'b00};

    assign rs_neg   = rs_val[31];
    assign rs_zero  = rs_val == '0;
    assign rs_eq_rt = rs_val == rt_val;

    ////////////////////////////////////////
    // condition and target
    always_comb begin
        br.taken  = 1'b0;
        br.target = br_target;
        case (ctrl.br_kind)
            BR_BEQ:  br.taken = rs_eq_rt;
            BR_BNE:  br.taken = !rs_eq_rt;
            BR_BGEZ: br.taken = !rs_neg;
            BR_BGTZ: br.taken = !rs_neg && !rs_zero;
            BR_BLEZ: br.taken = rs_neg || rs_zero;
            BR_BLTZ: br.taken = rs_neg;
            BR_J: begin
                br.taken  = 1'b1;
                br.target = j_target;
            end
            BR_JR: begin
                br.taken  = 1'b1;
                br.target = rs_val;
            end
            default: begin
                br.taken  = 1'b0;
                br.target = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/id_stage.sv
`timescale 1ns/1ns
`default_nettype none

module id_stage
    import mips_isa_pkg::*, id_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  stall_t     stall,
    input  if_id_t     if_id,
    input  inst_t      inst_rdata,
    input  reg_write_t wb,
    input  fwd_t       ex_fwd,
    input  fwd_t       mem_fwd,
    output id_ex_t     id_ex,
    output branch_t    br,
    output logic       stallreq
);

    logic      valid;
    word_t     pc;
    inst_t     inst;
    reg_addr_t rs;
    reg_addr_t rt;
    word_t     rf_rs;
    word_t     rf_rt;
    word_t     rs_val;
    word_t     rt_val;
    ctrl_t     ctrl;

    assign rs = inst[25:21];
    assign rt = inst[20:16];

    if_id_hold u_hold (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .if_id      (if_id),
        .inst_rdata (inst_rdata),
        .valid      (valid),
        .pc         (pc),
        .inst       (inst)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rs),
        .rdata2 (rf_rt),
        .wr     (wb)
    );

    operand_bypass u_bypass (
        .valid    (valid),
        .rs       (rs),
        .rt       (rt),
        .rf_rs    (rf_rs),
        .rf_rt    (rf_rt),
        .ex_fwd   (ex_fwd),
        .mem_fwd  (mem_fwd),
        .wb       (wb),
        .rs_val   (rs_val),
        .rt_val   (rt_val),
        .stallreq (stallreq)
    );

    inst_decoder u_decoder (
        .valid (valid),
        .inst  (inst),
        .ctrl  (ctrl)
    );

    branch_unit u_branch (
        .pc     (pc),
        .inst   (inst),
        .ctrl   (ctrl),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .br     (br)
    );

    // bundle for execute
    assign id_ex = '{pc: pc, inst: inst, ctrl: ctrl, rs_val: rs_val, rt_val: rt_val};

endmodule

`default_nettype wire

// File: tb/tb_id_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_id_stage
    import mips_isa_pkg::*, id_bus_pkg::*;
();

    logic       clk;
    logic       rst;
    stall_t     stall;
    if_id_t     if_id;
    inst_t      inst_rdata;
    reg_write_t wb;
    fwd_t       ex_fwd;
    fwd_t       mem_fwd;
    id_ex_t     id_ex;
    branch_t    br;
    logic       stallreq;

    // register model and decode register model
    word_t  model [32];
    if_id_t m_pc_q;
    logic   m_hold;
    inst_t  m_held;

    logic        chk_en;
    int          errors;
    int          n_checks;
    int          test_base;
    int unsigned seed;
    logic [107:0] fn_codes;
    logic [95:0]  op_codes;
    logic [19:0]  ri_codes;

    inst_t   e_inst;
    ctrl_t   e_ctrl;
    word_t   e_rs;
    word_t   e_rt;
    branch_t e_br;

    id_stage dut (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .if_id      (if_id),
        .inst_rdata (inst_rdata),
        .wb         (wb),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .id_ex      (id_ex),
        .br         (br),
        .stallreq   (stallreq)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (wb.we && wb.waddr != 5'd0) begin
            model[wb.waddr] <= wb.wdata;
        end
        if (rst) begin
            m_pc_q <= '0;
            m_hold <= 1'b0;
            m_held <= '0;
        end else begin
            // a moving fetch loads and a lone fetch stall gives a bubble
            if (!stall.if_stop) begin
                m_pc_q <= if_id;
            end else if (!stall.id_stop) begin
                m_pc_q <= '0;
            end
            if (stall.id_stop && !m_hold) begin
                m_hold <= 1'b1;
                m_held <= inst_rdata;
            end else if (!stall.id_stop) begin
                m_hold <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // reference functions
    function automatic ctrl_t link_ctrl(input br_kind_t kind, input reg_addr_t waddr);
        ctrl_t c;
        c = '0;
        c.alu_op.add = 1'b1;
        c.src1_sel   = 3'b010;
        c.src2_sel   = 4'b0100;
        c.rf_we      = 1'b1;
        c.rf_waddr   = waddr;
        c.link       = 1'b1;
        c.br_kind    = kind;
        return c;
    endfunction

    function automatic ctrl_t ref_ctrl(input logic valid, input inst_t i);
        ctrl_t c;
        logic [5:0] op;
        logic [5:0] fn;
        c  = '0;
        op = i[31:26];
        fn = i[5:0];
        if (!valid) return c;
        case (op)
            OP_SPECIAL: begin
                c.rf_we    = 1'b1;
                c.rf_waddr = i[15:11];
                c.src1_sel = 3'b001;
                c.src2_sel = 4'b0001;
                case (fn)
                    FN_ADD, FN_ADDU:  c.alu_op.add = 1'b1;
                    FN_SUB, FN_SUBU:  c.alu_op.sub = 1'b1;
                    FN_AND:           c.alu_op.and_op = 1'b1;
                    FN_OR:            c.alu_op.or_op = 1'b1;
                    FN_XOR:           c.alu_op.xor_op = 1'b1;
                    FN_NOR:           c.alu_op.nor_op = 1'b1;
                    FN_SLT:           c.alu_op.slt = 1'b1;
                    FN_SLTU:          c.alu_op.sltu = 1'b1;
                    FN_SLL, FN_SLLV:  c.alu_op.sll = 1'b1;
                    FN_SRL, FN_SRLV:  c.alu_op.srl = 1'b1;
                    FN_SRA, FN_SRAV:  c.alu_op.sra = 1'b1;
                    FN_JR: begin
                        c          = '0;
                        c.src1_sel = 3'b001;
                        c.br_kind  = BR_JR;
                    end
                    FN_JALR: c = link_ctrl(BR_JR, i[15:11]);
                    default: c = '0;
                endcase
                // constant shifts take sa as the first operand
                if (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA) c.src1_sel = 3'b100;
            end
            OP_REGIMM: begin
                case (i[20:16])
                    RT_BLTZ:   c.br_kind = BR_BLTZ;
                    RT_BGEZ:   c.br_kind = BR_BGEZ;
                    RT_BLTZAL: c = link_ctrl(BR_BLTZ, REG_LINK);
                    RT_BGEZAL: c = link_ctrl(BR_BGEZ, REG_LINK);
                    default:   c = '0;
                endcase
            end
            OP_J:    c.br_kind = BR_J;
            OP_JAL:  c = link_ctrl(BR_J, REG_LINK);
            OP_BEQ:  c.br_kind = BR_BEQ;
            OP_BNE:  c.br_kind = BR_BNE;
            OP_BLEZ: c.br_kind = BR_BLEZ;
            OP_BGTZ: c.br_kind = BR_BGTZ;
            default: begin
                // immediate group writes rt
                c.rf_we    = 1'b1;
                c.rf_waddr = i[20:16];
                c.src1_sel = 3'b001;
                c.src2_sel = 4'b0010;
                case (op)
                    OP_ADDI, OP_ADDIU, OP_LW, OP_SW: c.alu_op.add = 1'b1;
                    OP_SLTI:  c.alu_op.slt = 1'b1;
                    OP_SLTIU: c.alu_op.sltu = 1'b1;
                    OP_ANDI:  c.alu_op.and_op = 1'b1;
                    OP_ORI:   c.alu_op.or_op = 1'b1;
                    OP_XORI:  c.alu_op.xor_op = 1'b1;
                    OP_LUI:   c.alu_op.lui = 1'b1;
                    default:  c = '0;
                endcase
                if (op == OP_ANDI || op == OP_ORI || op == OP_XORI) c.src2_sel = 4'b1000;
                if (op == OP_LUI) c.src1_sel = 3'b000;
                if (op == OP_LW) begin
                    c.ram_en      = 1'b1;
                    c.rf_from_mem = 1'b1;
                end
                if (op == OP_SW) begin
                    c.ram_en   = 1'b1;
                    c.ram_wen  = 4'hf;
                    c.rf_we    = 1'b0;
                    c.rf_waddr = 5'd0;
                end
            end
        endcase
        return c;
    endfunction

    function automatic word_t ref_operand(input reg_addr_t a);
        if (a == 5'd0) return '0;
        if (ex_fwd.we && ex_fwd.waddr == a) return ex_fwd.wdata;
        if (mem_fwd.we && mem_fwd.waddr == a) return mem_fwd.wdata;
        if (wb.we && wb.waddr == a) return wb.wdata;
        return model[a];
    endfunction

    function automatic logic ref_stallreq(input logic valid, input inst_t i);
        return valid && ex_fwd.is_load && ex_fwd.we && ex_fwd.waddr != 5'd0
               && (ex_fwd.waddr == i[25:21] || ex_fwd.waddr == i[20:16]);
    endfunction

    function automatic branch_t ref_branch(input word_t pc, input inst_t i,
                                           input br_kind_t k, input word_t a, input word_t b);
        branch_t r;
        word_t   pc4;
        pc4      = pc + 32'd4;
        r.taken  = 1'b0;
        r.target = pc4 + {{14{i[15]}}, i[15:0], 2'b00};
        case (k)
            BR_BEQ:  r.taken = (a == b);
            BR_BNE:  r.taken = (a != b);
            BR_BGEZ: r.taken = ($signed(a) >= 0);
            BR_BGTZ: r.taken = ($signed(a) > 0);
            BR_BLEZ: r.taken = ($signed(a) <= 0);
            BR_BLTZ: r.taken = ($signed(a) < 0);
            BR_J: begin
                r.taken  = 1'b1;
                r.target = {pc4[31:28], i[25:0], 2'b00};
            end
            BR_JR: begin
                r.taken  = 1'b1;
                r.target = a;
            end
            default: r.taken = 1'b0;
        endcase
        return r;
    endfunction

    ////////////////////////////////////////
    // checking
    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    always @(negedge clk) begin
        if (chk_en) begin
            e_inst = m_hold ? m_held : inst_rdata;
            e_ctrl = ref_ctrl(m_pc_q.valid, e_inst);
            e_rs   = ref_operand(e_inst[25:21]);
            e_rt   = ref_operand(e_inst[20:16]);
            e_br   = ref_branch(m_pc_q.pc, e_inst, e_ctrl.br_kind, e_rs, e_rt);
            check("id_ex.pc", id_ex.pc, m_pc_q.pc);
            check("id_ex.inst", id_ex.inst, e_inst);
            check("id_ex.ctrl", id_ex.ctrl, e_ctrl);
            check("id_ex.rs_val", id_ex.rs_val, e_rs);
            check("id_ex.rt_val", id_ex.rt_val, e_rt);
            check("br.taken", br.taken, e_br.taken);
            if (e_ctrl.br_kind != BR_NONE) check("br.target", br.target, e_br.target);
            check("stallreq", stallreq, ref_stallreq(m_pc_q.valid, e_inst));
        end
    end

    task automatic check_idle();
        check("ctrl.rf_we", id_ex.ctrl.rf_we, 0);
        check("ctrl.ram_en", id_ex.ctrl.ram_en, 0);
        check("ctrl.ram_wen", id_ex.ctrl.ram_wen, 0);
        check("br.taken", br.taken, 0);
        check("stallreq", stallreq, 0);
    endtask

    task automatic finish_test(input string name);
        @(negedge clk);
        #1;
        if (errors == test_base) $display("test %-20s ok", name);
        else $display("test %-20s %0d mismatches", name, errors - test_base);
        test_base = errors;
        tick();
    endtask

    task automatic wait_for_stallreq(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (stallreq !== level && n < 4) begin
            @(negedge clk);
            n++;
        end
        if (stallreq !== level) begin
            errors++;
            $display("stallreq never settled to %0b within 4 cycles at %0t", level, $time);
        end
    endtask

    ////////////////////////////////////////
    // stimulus helpers
    function automatic word_t rand_pc();
        return $urandom & 32'hffff_fffc;
    endfunction

    function automatic word_t rand_data();
        return ($urandom_range(0, 7) == 0) ? 32'd0 : $urandom;
    endfunction

    // bias forwarding addresses toward the operands in use
    function automatic reg_addr_t pick_addr(input inst_t i);
        case ($urandom_range(0, 3))
            0:       return i[25:21];
            1:       return i[20:16];
            2:       return 5'd0;
            default: return $urandom;
        endcase
    endfunction

    function automatic inst_t rand_kept_inst();
        inst_t i;
        int    k;
        i = $urandom;
        k = $urandom_range(0, 37);
        if (k < 18) begin
            i[31:26] = OP_SPECIAL;
            i[5:0]   = fn_codes[k*6 +: 6];
        end else if (k < 22) begin
            i[31:26] = OP_REGIMM;
            i[20:16] = ri_codes[(k-18)*5 +: 5];
        end else begin
            i[31:26] = op_codes[(k-22)*6 +: 6];
        end
        return i;
    endfunction

    function automatic inst_t make_branch(input int k);
        inst_t i;
        i = $urandom;
        if ($urandom_range(0, 1) == 0) i[20:16] = i[25:21];
        if ($urandom_range(0, 3) == 0) i[25:21] = 5'd0;
        case (k)
            0:  i[31:26] = OP_BEQ;
            1:  i[31:26] = OP_BNE;
            2:  i[31:26] = OP_BLEZ;
            3:  i[31:26] = OP_BGTZ;
            4, 5, 6, 7: begin
                i[31:26] = OP_REGIMM;
                i[20:16] = ri_codes[(k-4)*5 +: 5];
            end
            8:  i[31:26] = OP_J;
            9:  i[31:26] = OP_JAL;
            default: begin
                i[31:26] = OP_SPECIAL;
                i[5:0]   = (k == 10) ? FN_JR : FN_JALR;
            end
        endcase
        return i;
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic drive_buses(input inst_t i);
        ex_fwd  = {($urandom_range(0, 3) == 0), ($urandom_range(0, 1) == 1),
                   pick_addr(i), rand_data()};
        mem_fwd = {1'b0, ($urandom_range(0, 1) == 1), pick_addr(i), rand_data()};
        wb      = {($urandom_range(0, 1) == 1), pick_addr(i), rand_data()};
    endtask

    // pc goes in one cycle and its instruction word arrives the next
    task automatic issue(input word_t pc, input inst_t i);
        if_id = {1'b1, pc};
        tick();
        inst_rdata = i;
        drive_buses(i);
    endtask

    ////////////////////////////////////////
    // test sequence
    initial begin
        inst_t     first_inst;
        inst_t     next_inst;
        inst_t     i;
        int        n;
        int        lvl;
        reg_addr_t r;
        reg_addr_t ra;
        word_t     exp;
        seed = 32'h2071;
        void'($urandom(seed));
        fn_codes = {FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_JR, FN_JALR,
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                    FN_SLT, FN_SLTU};
        op_codes = {OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_ADDI, OP_ADDIU,
                    OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW, OP_SW};
        ri_codes = {RT_BGEZAL, RT_BLTZAL, RT_BGEZ, RT_BLTZ};
        rst        = 1'b1;
        stall      = '0;
        // a valid fetch during reset must not reach decode
        if_id      = {1'b1, rand_pc()};
        inst_rdata = '0;
        wb         = '0;
        ex_fwd     = '0;
        mem_fwd    = '0;
        chk_en     = 1'b0;
        errors     = 0;
        n_checks   = 0;
        test_base  = 0;
        repeat (8) @(posedge clk);
        #2;
        rst    = 1'b0;
        chk_en = 1'b1;

        // idle after reset, then fill every register through writeback
        @(negedge clk);
        check_idle();
        tick();
        for (n = 1; n < 32; n++) begin
            wb = {1'b1, n[4:0], $urandom};
            tick();
        end
        wb = '0;
        // fetch held while decode runs so bubbles enter
        issue(rand_pc(), rand_kept_inst());
        stall = 2'b10;
        for (n = 0; n < 3; n++) begin
            tick();
            inst_rdata = rand_kept_inst();
            ex_fwd     = {1'b1, 1'b1, inst_rdata[25:21], rand_data()};
            @(negedge clk);
            check_idle();
        end
        tick();
        stall = '0;
        finish_test("reset and bubble");

        for (n = 0; n < 60; n++) issue(rand_pc(), rand_kept_inst());
        finish_test("random decode");

        for (lvl = 0; lvl < 5; lvl++) begin
            r = $urandom_range(1, 31);
            if (lvl == 4) r = 5'd0;
            issue(rand_pc(), {OP_SPECIAL, r, r, 5'd3, 5'd0, FN_ADDU});
            ex_fwd  = {1'b0, (lvl < 1 || lvl == 4), r, $urandom};
            mem_fwd = {1'b0, (lvl < 2 || lvl == 4), r, $urandom};
            wb      = {(lvl < 3 || lvl == 4), r, $urandom};
            if (lvl == 0) exp = ex_fwd.wdata;
            else if (lvl == 1) exp = mem_fwd.wdata;
            else if (lvl == 2) exp = wb.wdata;
            else if (lvl == 3) exp = model[r];
            else exp = '0;
            @(negedge clk);
            check("rs_val priority", id_ex.rs_val, exp);
            tick();
        end
        finish_test("operand priority");

        for (n = 0; n < 48; n++) issue(rand_pc(), make_branch(n % 12));
        finish_test("branch and jump");

        for (n = 0; n < 6; n++) begin
            ra = $urandom_range(1, 14);
            i  = {OP_SPECIAL, (n == 3) ? 5'd0 : ra, ra + 5'd16, 5'd2, 5'd0, FN_ADDU};
            issue(rand_pc(), i);
            mem_fwd = '0;
            wb      = '0;
            case (n)
                0:       ex_fwd = {1'b1, 1'b1, ra, rand_data()};
                1:       ex_fwd = {1'b1, 1'b1, ra + 5'd16, rand_data()};
                2:       ex_fwd = {1'b1, 1'b1, 5'd31, rand_data()};
                3:       ex_fwd = {1'b1, 1'b1, 5'd0, rand_data()};
                4:       ex_fwd = {1'b0, 1'b1, ra, rand_data()};
                default: ex_fwd = {1'b1, 1'b0, ra, rand_data()};
            endcase
            wait_for_stallreq(n < 2);
            tick();
        end
        finish_test("load-use stall");

        first_inst = rand_kept_inst();
        issue(rand_pc(), first_inst);
        stall = 2'b11;
        for (n = 0; n < 5; n++) begin
            tick();
            inst_rdata = rand_kept_inst();
            drive_buses(first_inst);
            @(negedge clk);
            check("id_ex.inst held", id_ex.inst, first_inst);
        end
        tick();
        stall     = '0;
        next_inst = rand_kept_inst();
        issue(rand_pc(), next_inst);
        @(negedge clk);
        check("id_ex.inst released", id_ex.inst, next_inst);
        finish_test("decode stall hold");

        $display("checks %0d, mismatches %0d", n_checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
verilog/mips_isa_pkg.sv
verilog/id_bus_pkg.sv
verilog/regfile.sv
verilog/if_id_hold.sv
verilog/operand_bypass.sv
verilog/inst_decoder.sv
verilog/branch_unit.sv
verilog/id_stage.sv
tb/tb_id_stage.sv
